/* source/bcd_display_pkg.sv */
// Segments are active low with bit 0 as segment a and the decimal point is always held off

package bcd_display_pkg;

	////////////////////
	// Digit and segment types
	////////////////////

	// One decimal digit in BCD form
	// Values 10 to 15 never come out of the converter but the decoder still handles them
	typedef logic [3:0] bcd_digit_t;

	// Segment pattern ordered g f e d c b a from bit 6 down to bit 0
	// A low bit lights the segment
	typedef logic [6:0] seg_t;

	// Everything that goes to the cathode side of one display digit
	typedef struct packed {
		seg_t segments;
		logic dp;
	} seg_drive_t;

	////////////////////
	// Fixed patterns
	////////////////////

	// All segments dark, used for blanked leading zeros
	localparam seg_t SEG_BLANK = 7'h7F;

	// Only segment g lit, shown for digit codes above 9
	localparam seg_t SEG_DASH = 7'h3F;

	// Decimal point level that keeps the point dark
	localparam logic DP_OFF = 1'b1;

endpackage

/* source/bcd_converter.sv */
// Serial double dabble that drops starts while busy and needs digits for 2**INPUT_WIDTH-1
`timescale 1ns/1ps

module bcd_converter #(
	parameter int INPUT_WIDTH    = 13,
	parameter int DECIMAL_DIGITS = 4
) (
	input  logic                        i_Clock,
	input  logic                        i_arst_n,
	input  logic [INPUT_WIDTH-1:0]      i_binary,
	input  logic                        i_start,
	output logic [DECIMAL_DIGITS*4-1:0] o_bcd,
	output logic                        o_dv,
	output logic                        o_busy
);

	////////////////////
	// Counter widths
	////////////////////

	// The loop counter runs from 0 up to INPUT_WIDTH-1
	localparam int LOOP_W = (INPUT_WIDTH > 1) ? $clog2(INPUT_WIDTH) : 1;

	// The digit index runs from 0 up to DECIMAL_DIGITS-1
	localparam int DIGIT_W = (DECIMAL_DIGITS > 1) ? $clog2(DECIMAL_DIGITS) : 1;

	localparam logic [LOOP_W-1:0]  LOOP_LAST  = LOOP_W'(INPUT_WIDTH - 1);
	localparam logic [DIGIT_W-1:0] DIGIT_LAST = DIGIT_W'(DECIMAL_DIGITS - 1);

	////////////////////
	// FSM state
	////////////////////

	typedef enum logic [2:0] {
		S_IDLE,
		S_SHIFT,
		S_CHECK_SHIFT_INDEX,
		S_ADD,
		S_CHECK_DIGIT_INDEX,
		S_DONE
	} state_t;

	state_t r_state;

	// BCD result being built up, one shifted bit at a time
	logic [DECIMAL_DIGITS*4-1:0] r_bcd;

	// Copy of the input that is emptied from its top bit
	logic [INPUT_WIDTH-1:0] r_binary;

	// Digit currently being checked for the add-three step
	logic [DIGIT_W-1:0] r_digit_idx;

	// Number of bits already shifted, minus one
	logic [LOOP_W-1:0] r_loop_count;

	logic r_dv;
	logic r_busy;

	// Digit picked out by the current digit index
	logic [3:0] w_bcd_digit;

	assign w_bcd_digit = r_bcd[r_digit_idx*4 +: 4];

	always_ff @(posedge i_Clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			r_state      <= S_IDLE;
			r_bcd        <= '0;
			r_binary     <= '0;
			r_digit_idx  <= '0;
			r_loop_count <= '0;
			r_dv         <= 1'b0;
			r_busy       <= 1'b0;
		end else begin
			// The valid strobe lasts a single cycle unless the done state sets it again
			r_dv <= 1'b0;

			case (r_state)
				// Wait for a start and take a fresh copy of the input
				S_IDLE: begin
					if (i_start) begin
						r_binary <= i_binary;
						r_bcd    <= '0;
						r_busy   <= 1'b1;
						r_state  <= S_SHIFT;
					end
				end

				// Move the top input bit into the bottom of the BCD vector
				S_SHIFT: begin
					r_bcd    <= {r_bcd[DECIMAL_DIGITS*4-2:0], r_binary[INPUT_WIDTH-1]};
					r_binary <= r_binary << 1;
					r_state  <= S_CHECK_SHIFT_INDEX;
				end

				// After the last shift the digits are already final and no correction follows
				S_CHECK_SHIFT_INDEX: begin
					if (r_loop_count == LOOP_LAST) begin
						r_loop_count <= '0;
						r_state      <= S_DONE;
					end else begin
						r_loop_count <= r_loop_count + 1'b1;
						r_state      <= S_ADD;
					end
				end

				// A digit of 5 or more would overflow on the next doubling so it gets 3 added
				S_ADD: begin
					if (w_bcd_digit > 4'd4) begin
						r_bcd[r_digit_idx*4 +: 4] <= w_bcd_digit + 4'd3;
					end
					r_state <= S_CHECK_DIGIT_INDEX;
				end

				// Walk through every digit before the next shift
				S_CHECK_DIGIT_INDEX: begin
					if (r_digit_idx == DIGIT_LAST) begin
						r_digit_idx <= '0;
						r_state     <= S_SHIFT;
					end else begin
						r_digit_idx <= r_digit_idx + 1'b1;
						r_state     <= S_ADD;
					end
				end

				// Busy drops on the same edge that raises the valid strobe
				S_DONE: begin
					r_dv    <= 1'b1;
					r_busy  <= 1'b0;
					r_state <= S_IDLE;
				end

				default: begin
					r_state <= S_IDLE;
				end
			endcase
		end
	end

	// The result register holds its value until the next accepted start clears it
	assign o_bcd  = r_bcd;
	assign o_dv   = r_dv;
	assign o_busy = r_busy;

endmodule

/* source/display_scan.sv */
// Multiplexed common-anode scan with active-low anodes and segments and SCAN_DIV of at least 1
`timescale 1ns/1ps

module display_scan #(
	parameter int DECIMAL_DIGITS = 4,
	parameter int SCAN_DIV       = 4
) (
	input  logic                        i_Clock,
	input  logic                        i_arst_n,
	input  logic [DECIMAL_DIGITS*4-1:0] i_frame,
	output logic [DECIMAL_DIGITS-1:0]   o_anodes,
	output bcd_display_pkg::seg_drive_t o_drive
);

	import bcd_display_pkg::*;

	////////////////////
	// Scan counters
	////////////////////

	localparam int DIV_W   = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
	localparam int DIGIT_W = (DECIMAL_DIGITS > 1) ? $clog2(DECIMAL_DIGITS) : 1;

	localparam logic [DIV_W-1:0]   DIV_LAST   = DIV_W'(SCAN_DIV - 1);
	localparam logic [DIGIT_W-1:0] DIGIT_LAST = DIGIT_W'(DECIMAL_DIGITS - 1);

	// Prescaler that sets how long each digit stays lit
	logic [DIV_W-1:0] r_div_count;

	// Digit currently shown on the display
	logic [DIGIT_W-1:0] r_digit_idx;

	logic               w_step;
	logic [DIGIT_W-1:0] w_next_idx;

	// Active-low segment pattern for one BCD digit
	// Codes above 9 fall back to a dash so a bad frame is visible
	function automatic seg_t decode_digit(input bcd_digit_t digit);
		case (digit)
			4'd0:    decode_digit = 7'h40;
			4'd1:    decode_digit = 7'h79;
			4'd2:    decode_digit = 7'h24;
			4'd3:    decode_digit = 7'h30;
			4'd4:    decode_digit = 7'h19;
			4'd5:    decode_digit = 7'h12;
			4'd6:    decode_digit = 7'h02;
			4'd7:    decode_digit = 7'h78;
			4'd8:    decode_digit = 7'h00;
			4'd9:    decode_digit = 7'h10;
			default: decode_digit = SEG_DASH;
		endcase
	endfunction

	// The step fires on the last prescaler count and moves to the next digit
	assign w_step     = (r_div_count == DIV_LAST);
	assign w_next_idx = (r_digit_idx == DIGIT_LAST) ? '0 : r_digit_idx + 1'b1;

	////////////////////
	// Blanking and decode
	////////////////////

	// Frame split into its digits with digit 0 at the bottom
	bcd_digit_t [DECIMAL_DIGITS-1:0] w_digits;

	// Set when a digit and all digits above it are zero
	logic [DECIMAL_DIGITS-1:0] w_lead_zero;

	logic       w_blank;
	seg_drive_t w_next_drive;

	assign w_digits = i_frame;

	// Zeros are tracked from the most significant digit downward
	always_comb begin
		w_lead_zero[DECIMAL_DIGITS-1] = (w_digits[DECIMAL_DIGITS-1] == 4'd0);
		for (int k = DECIMAL_DIGITS - 2; k >= 0; k--) begin
			w_lead_zero[k] = (w_digits[k] == 4'd0) && w_lead_zero[k + 1];
		end
	end

	// Digit 0 always shows so a zero value still reads "0"
	assign w_blank = w_lead_zero[w_next_idx] && (w_next_idx != '0);

	always_comb begin
		w_next_drive.dp       = DP_OFF;
		w_next_drive.segments = w_blank ? SEG_BLANK : decode_digit(w_digits[w_next_idx]);
	end

	////////////////////
	// Registered outputs
	////////////////////

	// Anode and segments load on the same step so no ghost digit appears
	// The frame is sampled only at a step and is held for the whole digit period
	always_ff @(posedge i_Clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			r_div_count <= '0;
			r_digit_idx <= '0;
			o_anodes    <= ~DECIMAL_DIGITS'(1);
			o_drive     <= '{segments: decode_digit(4'd0), dp: DP_OFF};
		end else begin
			if (w_step) begin
				r_div_count <= '0;
				r_digit_idx <= w_next_idx;
				o_anodes    <= ~(DECIMAL_DIGITS'(1) << w_next_idx);
				o_drive     <= w_next_drive;
			end else begin
				r_div_count <= r_div_count + 1'b1;
			end
		end
	end

endmodule

/* source/bcd_display.sv */
// Holds the last result and drops a start while busy with no overflow check on i_binary
`timescale 1ns/1ps

module bcd_display #(
	parameter int INPUT_WIDTH    = 13,
	parameter int DECIMAL_DIGITS = 4,
	parameter int SCAN_DIV       = 4
) (
	input  logic                        i_Clock,
	input  logic                        i_arst_n,
	input  logic [INPUT_WIDTH-1:0]      i_binary,
	input  logic                        i_start,
	output logic [DECIMAL_DIGITS*4-1:0] o_bcd,
	output logic                        o_dv,
	output logic                        o_busy,
	output logic [DECIMAL_DIGITS-1:0]   o_anodes,
	output bcd_display_pkg::seg_drive_t o_drive
);

	// Latest finished result, which the scanner reads continuously
	logic [DECIMAL_DIGITS*4-1:0] r_frame;

	////////////////////
	// Conversion
	////////////////////

	// Converter outputs go straight to the top-level ports
	bcd_converter #(
		.INPUT_WIDTH    (INPUT_WIDTH),
		.DECIMAL_DIGITS (DECIMAL_DIGITS)
	) bcd_converter_inst (
		.i_Clock  (i_Clock),
		.i_arst_n (i_arst_n),
		.i_binary (i_binary),
		.i_start  (i_start),
		.o_bcd    (o_bcd),
		.o_dv     (o_dv),
		.o_busy   (o_busy)
	);

	// A new result simply overwrites the old frame one cycle after the valid strobe
	always_ff @(posedge i_Clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			r_frame <= '0;
		end else if (o_dv) begin
			r_frame <= o_bcd;
		end
	end

	////////////////////
	// Display
	////////////////////

	// The scanner picks up a changed frame at its next digit step
	display_scan #(
		.DECIMAL_DIGITS (DECIMAL_DIGITS),
		.SCAN_DIV       (SCAN_DIV)
	) display_scan_inst (
		.i_Clock  (i_Clock),
		.i_arst_n (i_arst_n),
		.i_frame  (r_frame),
		.o_anodes (o_anodes),
		.o_drive  (o_drive)
	);

endmodule

/* test/bcd_display_tb.sv */
// Runs from the project root to find its golden file and fixes INPUT_WIDTH 13, 4 digits, SCAN_DIV 4
`timescale 1ns/1ps

module bcd_display_tb;

	import bcd_display_pkg::*;

	localparam int INPUT_WIDTH    = 13;
	localparam int DECIMAL_DIGITS = 4;
	localparam int SCAN_DIV       = 4;
	localparam int CLK_PERIOD     = 20;
	localparam int RESET_CYCLES   = 5;
	localparam int SCAN_CYCLES    = DECIMAL_DIGITS * SCAN_DIV;

	// Accept edge and done edge, a shift and check per bit, an add and check per digit in between
	localparam int WORST_CONV = 2 + 2 * INPUT_WIDTH + 2 * DECIMAL_DIGITS * (INPUT_WIDTH - 1);

	// One golden line with the segment pattern of digit 0 in the lowest slot
	typedef struct packed {
		logic [INPUT_WIDTH-1:0]      binary;
		logic [DECIMAL_DIGITS*4-1:0] bcd;
		seg_t [DECIMAL_DIGITS-1:0]   segs;
	} golden_vec_t;

	logic                        i_Clock;
	logic                        i_arst_n;
	logic [INPUT_WIDTH-1:0]      i_binary;
	logic                        i_start;
	logic [DECIMAL_DIGITS*4-1:0] o_bcd;
	logic                        o_dv;
	logic                        o_busy;
	logic [DECIMAL_DIGITS-1:0]   o_anodes;
	seg_drive_t                  o_drive;

	golden_vec_t vectors[$];
	logic        vectors_loaded = 1'b0;

	bcd_display #(
		.INPUT_WIDTH    (INPUT_WIDTH),
		.DECIMAL_DIGITS (DECIMAL_DIGITS),
		.SCAN_DIV       (SCAN_DIV)
	) bcd_display_inst (
		.i_Clock  (i_Clock),
		.i_arst_n (i_arst_n),
		.i_binary (i_binary),
		.i_start  (i_start),
		.o_bcd    (o_bcd),
		.o_dv     (o_dv),
		.o_busy   (o_busy),
		.o_anodes (o_anodes),
		.o_drive  (o_drive)
	);

	initial begin
		i_Clock = 1'b0;
		forever #(CLK_PERIOD / 2) i_Clock = ~i_Clock;
	end

	////////////////////
	// Helpers
	////////////////////

	task automatic abort_run();
		$display("Testbench failed");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("[ERROR] time %0t: %s expected %0h, got %0h", $time, name, expected, actual);
			abort_run();
		end
	endtask

	// Inputs change 2 ns after the rising edge and outputs are read at the same point
	task automatic next_cycle();
		@(posedge i_Clock);
		#2;
	endtask

	// Index of the low anode, or -1 when none is low
	function automatic int active_digit(input logic [DECIMAL_DIGITS-1:0] anodes);
		int idx;
		idx = -1;
		for (int k = 0; k < DECIMAL_DIGITS; k++) begin
			if (!anodes[k]) begin
				idx = k;
			end
		end
		return idx;
	endfunction

	// Lines that do not hold six fields, comments included, are skipped
	task automatic load_golden();
		int          fd;
		int          count;
		string       text;
		int unsigned value;
		logic [31:0] bcd;
		logic [31:0] s0;
		logic [31:0] s1;
		logic [31:0] s2;
		logic [31:0] s3;
		golden_vec_t vec;
		fd = $fopen("test/bcd_display_golden.txt", "r");
		if (fd == 0) begin
			$display("Could not open the golden vector file test/bcd_display_golden.txt");
			abort_run();
		end else begin
			while (!$feof(fd)) begin
				text = "";
				void'($fgets(text, fd));
				count = $sscanf(text, "%d %h %h %h %h %h", value, bcd, s0, s1, s2, s3);
				if (count == 6) begin
					vec.binary = value[INPUT_WIDTH-1:0];
					vec.bcd    = bcd[DECIMAL_DIGITS*4-1:0];
					vec.segs   = {s3[6:0], s2[6:0], s1[6:0], s0[6:0]};
					vectors.push_back(vec);
				end
			end
			$fclose(fd);
		end
	endtask

	////////////////////
	// Conversion and display checks
	////////////////////

	task automatic run_conversion(input golden_vec_t vec);
		int gap;
		gap = $urandom_range(5, 0);
		repeat (gap) begin
			next_cycle();
			compare_value("o_busy", 0, o_busy);
			compare_value("o_dv", 0, o_dv);
		end
		i_binary = vec.binary;
		i_start  = 1'b1;
		next_cycle();
		compare_value("o_busy", 1, o_busy);
		// Second start with another value arrives while busy and has to be dropped
		i_binary = vec.binary + 1'b1;
		next_cycle();
		i_start = 1'b0;
		while (!o_dv) begin
			compare_value("o_busy", 1, o_busy);
			next_cycle();
		end
		compare_value("o_busy", 0, o_busy);
		compare_value("o_bcd", vec.bcd, o_bcd);
	endtask

	task automatic check_display(input golden_vec_t vec);
		int                        digit;
		int                        prev_digit;
		int                        run_len;
		logic                      first_run;
		logic [DECIMAL_DIGITS-1:0] seen;
		// Almost a full scan lets the new frame reach every digit, and o_dv must stay low
		repeat (SCAN_CYCLES - 1) begin
			next_cycle();
			compare_value("o_dv", 0, o_dv);
		end
		prev_digit = -1;
		run_len    = 0;
		first_run  = 1'b1;
		seen       = '0;
		// A scan plus one cycle covers every digit step, the wrap included
		repeat (SCAN_CYCLES + 1) begin
			next_cycle();
			compare_value("o_dv", 0, o_dv);
			compare_value("low anode count", 1, $countones(~o_anodes));
			digit = active_digit(o_anodes);
			compare_value("o_drive.segments", vec.segs[digit], o_drive.segments);
			compare_value("o_drive.dp", 1, o_drive.dp);
			if (digit != prev_digit) begin
				if (prev_digit >= 0) begin
					compare_value("next scan digit", (prev_digit + 1) % DECIMAL_DIGITS, digit);
					// The first run of the window may have started before it
					if (!first_run) begin
						compare_value("digit active cycles", SCAN_DIV, run_len);
					end
					first_run = 1'b0;
				end
				run_len = 0;
			end
			seen[digit] = 1'b1;
			run_len++;
			prev_digit = digit;
		end
		compare_value("digits visited", {DECIMAL_DIGITS{1'b1}}, seen);
		compare_value("o_bcd held", vec.bcd, o_bcd);
	endtask

	////////////////////
	// Watchdog
	////////////////////

	initial begin
		longint limit_cycles;
		wait (vectors_loaded);
		limit_cycles = vectors.size() * (WORST_CONV + 2 * SCAN_CYCLES + 10) + RESET_CYCLES + 10;
		#(limit_cycles * CLK_PERIOD);
		$display("Timeout: the test did not finish within %0d clock cycles", limit_cycles);
		abort_run();
	end

	initial begin
		void'($urandom(92));
		$timeformat(-9, 0, " ns", 0);
		i_arst_n = 1'b0;
		i_start  = 1'b0;
		i_binary = '0;
		load_golden();
		if (vectors.size() == 0) begin
			$display("The golden vector file holds no usable lines");
			abort_run();
		end
		vectors_loaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge i_Clock);
		#2;
		// Reset state: idle converter, digit 0 lit and showing "0"
		compare_value("o_dv", 0, o_dv);
		compare_value("o_busy", 0, o_busy);
		compare_value("o_anodes", 4'b1110, o_anodes);
		compare_value("o_drive.segments", 7'h40, o_drive.segments);
		i_arst_n = 1'b1;
		foreach (vectors[i]) begin
			run_conversion(vectors[i]);
			check_display(vectors[i]);
		end
		$display("Testbench passed");
		$finish;
	end

endmodule

/* test/bcd_display_golden.txt */
# Columns: binary input (decimal), BCD word (hex), segments of digit 0, 1, 2, 3 (hex)
# Segments are active low with bit 0 as segment a and 7F marks a blanked digit
0 0000 40 7F 7F 7F
7 0007 78 7F 7F 7F
9 0009 10 7F 7F 7F
10 0010 40 79 7F 7F
40 0040 40 19 7F 7F
99 0099 10 10 7F 7F
100 0100 40 40 79 7F
505 0505 12 40 12 7F
999 0999 10 10 10 7F
1000 1000 40 40 40 79
1234 1234 19 30 24 79
2357 2357 78 12 30 24
4095 4095 12 10 40 19
5678 5678 00 78 02 12
6789 6789 10 00 78 02
8191 8191 79 10 79 00

/* bcd_display.f */
source/bcd_display_pkg.sv
source/bcd_converter.sv
source/display_scan.sv
source/bcd_display.sv
test/bcd_display_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := bcd_display_tb
FILELIST  := bcd_display.f
SIM       := obj_dir/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "^Testbench passed$$"

clean:
	rm -rf obj_dir
